//--- verilog.f
+incdir+.
tidc_pkg.sv
tidc_source_pool.sv
tidc_request_ctrl.sv
tidc_message_builder.sv
tidc_response_match.sv
tidc_l1_adapter.sv
tb_tidc_l1_adapter.sv

//--- Makefile
# Verilator build and run for the L1 TileLink adapter

VERILATOR ?= verilator
TOP       ?= tb_tidc_l1_adapter
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_tidc_l1_adapter.sv
// Testbench for the L1 TileLink adapter
// Stimulus table, L2 responder with random ready stalls, checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "tidc_defs.svh"

module tb_tidc_l1_adapter;

    import tidc_pkg::*;

    localparam int NUM_ROWS  = 10;
    localparam int MAX_DELAY = 6;

    typedef struct packed {
        l1_req_e     typ;
        logic [31:0] addr;
        logic [2:0]  perm;
        logic [63:0] data;
        logic [7:0]  delay;
        d_opcode_e   op;
        logic [63:0] rdata;
        logic        err;
        logic [3:0]  sink;
        logic        stray;
    } row_t;

    logic clk;
    logic rst_n;
    logic l1_req_valid;
    logic l1_req_ready;
    l1_req_e l1_req_type;
    logic [31:0] l1_req_addr;
    perm_u l1_req_perm;
    logic [63:0] l1_req_data;
    logic l1_data_valid;
    logic [63:0] l1_data;
    logic l1_data_error;
    logic a_valid, a_ready, c_valid, c_ready, e_valid, e_ready;
    logic [2:0] a_opcode, a_param, c_opcode, c_param;
    logic [3:0] a_size, a_source, c_size, c_source, e_sink;
    logic [31:0] a_address, c_address;
    logic [63:0] a_data, c_data;
    logic [7:0] a_mask;
    logic d_valid, d_error, d_ready;
    logic [2:0] d_opcode;
    logic [3:0] d_source, d_sink;
    logic [63:0] d_data;

    row_t        rows [NUM_ROWS];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          hs_count [3];
    int          pulses;

    tidc_l1_adapter dut0 (.*);

    always #5 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // L2 ready model, one LFSR step per ready bit
    always @(posedge clk) begin
        if (rst_n) begin
            #1;
            lfsr    = lfsr_next(lfsr);
            a_ready = lfsr[0];
            lfsr    = lfsr_next(lfsr);
            c_ready = lfsr[0];
            lfsr    = lfsr_next(lfsr);
            e_ready = lfsr[0];
        end
    end

    // Handshakes and data pulses seen on the bus
    always @(negedge clk) begin
        if (rst_n) begin
            if (a_valid && a_ready) hs_count[0]++;
            if (c_valid && c_ready) hs_count[1]++;
            if (e_valid && e_ready) hs_count[2]++;
            if (l1_data_valid) pulses++;
        end
    end

    task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Failure: %s", what);
        end
    endtask

    function automatic logic [127:0] channel_word(input int ch);
        case (ch)
            0:       return {10'b0, a_opcode, a_param, a_size, a_source, a_address, a_data, a_mask};
            1:       return {18'b0, c_opcode, c_param, c_size, c_source, c_address, c_data};
            default: return {124'b0, e_sink};
        endcase
    endfunction

    function automatic logic channel_valid(input int ch);
        return (ch == 0) ? a_valid : (ch == 1) ? c_valid : e_valid;
    endfunction

    function automatic logic channel_ready(input int ch);
        return (ch == 0) ? a_ready : (ch == 1) ? c_ready : e_ready;
    endfunction

    // Samples at falling edges until valid and ready meet on one channel
    task automatic await_handshake(input int ch, input logic [127:0] exp, input string name,
                                   input logic sample_now);
        logic [127:0] first;
        logic         v;
        bit           seen;
        seen = 0;
        if (!sample_now) @(negedge clk);
        forever begin
            v = channel_valid(ch);
            if (!seen) begin
                check_true(v, {name, " valid did not rise on time"});
                check_value({name, " fields"}, exp, channel_word(ch));
                first = channel_word(ch);
                seen  = 1;
            end else begin
                check_value({name, " stable under stall"}, first, channel_word(ch));
            end
            check_true(!l1_req_ready, {name, " l1_req_ready high mid transaction"});
            if (v && channel_ready(ch)) break;
            @(negedge clk);
        end
    endtask

    task automatic drive_beat(input logic [2:0] op, input logic [3:0] src, input row_t r);
        @(posedge clk);
        #1;
        d_valid  = 1'b1;
        d_opcode = op;
        d_source = src;
        d_sink   = r.sink;
        d_data   = r.rdata;
        d_error  = r.err;
    endtask

    task automatic run_row(input int i, input logic [3:0] src);
        row_t  r;
        int    ch;
        int    hs0 [3];
        int    p0;
        bit    grant;
        bit    has_data;
        logic [2:0]  exp_op;
        logic [63:0] exp_data;
        string tag;
        r        = rows[i];
        tag      = $sformatf("row%0d", i);
        grant    = (r.typ == L1_READ_MISS) || (r.typ == L1_WRITE_MISS);
        has_data = (r.op == D_GRANT_DATA) || (r.op == D_ACCESS_ACK_DATA);
        ch       = (r.typ == L1_WRITE_BACK) ? 1 : 0;
        exp_op   = grant ? 3'(A_ACQUIRE_BLOCK) : (r.typ == L1_UNCACHED_READ) ? 3'(A_GET) :
                   3'(A_PUT_FULL_DATA);
        exp_data = (r.typ == L1_UNCACHED_WRITE) ? r.data : 64'd0;

        do @(negedge clk); while (!l1_req_ready);
        hs0 = hs_count;
        p0  = pulses;
        @(posedge clk);
        #1;
        l1_req_valid = 1'b1;
        l1_req_type  = r.typ;
        l1_req_addr  = r.addr;
        l1_req_perm  = perm_u'(r.perm);
        l1_req_data  = r.data;
        @(posedge clk);
        #1;
        l1_req_valid = 1'b0;

        // Request message on A or C
        if (ch == 0) begin
            await_handshake(0, {10'b0, exp_op, grant ? r.perm : 3'd0, 4'd5, src, r.addr,
                            exp_data, 8'hFF}, {tag, " A"}, 1'b0);
        end else begin
            await_handshake(1, {18'b0, 3'(C_RELEASE_DATA), r.perm, 4'd5, src, r.addr, r.data},
                            {tag, " C"}, 1'b0);
        end
        @(negedge clk);
        check_true(!channel_valid(ch), {tag, " message valid held after handshake"});

        // L2 response, strays first
        repeat (r.delay) @(posedge clk);
        if (r.stray) begin
            drive_beat(r.op, src ^ 4'd1, r);
            drive_beat(grant ? 3'(D_ACCESS_ACK_DATA) : 3'(D_GRANT_DATA), src, r);
        end
        drive_beat(r.op, src, r);
        @(posedge clk);
        #1;
        d_valid = 1'b0;
        @(negedge clk);
        check_true(d_ready, {tag, " d_ready low while a response is awaited"});
        check_value({tag, " l1_data_valid"}, 128'(has_data), 128'(l1_data_valid));
        if (has_data) begin
            check_value({tag, " l1_data"}, 128'(r.rdata), 128'(l1_data));
            check_value({tag, " l1_data_error"}, 128'(r.err), 128'(l1_data_error));
        end

        // Controller leaves the wait state one cycle after resp_done
        @(negedge clk);
        if (grant) begin
            await_handshake(2, 128'(r.sink), {tag, " E"}, 1'b1);
            @(negedge clk);
            check_true(!e_valid, {tag, " e_valid held after handshake"});
        end
        check_true(l1_req_ready, {tag, " l1_req_ready not back one cycle after the end"});
        @(negedge clk);

        check_value({tag, " data pulses"}, 128'(has_data), 128'(pulses - p0));
        check_value({tag, " A handshakes"}, 128'(ch == 0), 128'(hs_count[0] - hs0[0]));
        check_value({tag, " C handshakes"}, 128'(ch == 1), 128'(hs_count[1] - hs0[1]));
        check_value({tag, " E handshakes"}, 128'(grant), 128'(hs_count[2] - hs0[2]));
    endtask

    task automatic set_row(input int i, input l1_req_e typ, input logic [31:0] addr,
                           input logic [2:0] perm, input logic [63:0] data, input logic [7:0] dly,
                           input d_opcode_e op, input logic [63:0] rdata, input logic err,
                           input logic [3:0] sink, input logic stray);
        rows[i] = '{typ, addr, perm, data, dly, op, rdata, err, sink, stray};
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        logic [3:0] src;
        clk = 0;
        rst_n = 0;
        lfsr = 32'h082742d0;
        errors = 0;
        checks = 0;
        pulses = 0;
        hs_count = '{0, 0, 0};
        {l1_req_valid, a_ready, c_ready, e_ready, d_valid, d_error} = '0;
        l1_req_type = L1_READ_MISS;
        l1_req_addr = '0;
        l1_req_perm = '0;
        l1_req_data = '0;
        d_opcode = '0;
        d_source = '0;
        d_sink = '0;
        d_data = '0;

        set_row(0, L1_READ_MISS, 32'h1000_0040, 3'd0, 64'd0, 2, D_GRANT_DATA,
                64'h1111_2222_3333_4444, 0, 4'd3, 0);
        set_row(1, L1_WRITE_MISS, 32'h2000_0080, 3'd1, 64'd0, 0, D_GRANT, 64'd0, 0, 4'd5, 1);
        set_row(2, L1_WRITE_BACK, 32'h3000_00C0, 3'd1, 64'hDEAD_BEEF_0123_4567, 3,
                D_RELEASE_ACK, 64'd0, 0, 4'd0, 0);
        set_row(3, L1_UNCACHED_READ, 32'h4000_0008, 3'd2, 64'h3C3C_4B4B_5A5A_6969, 1,
                D_ACCESS_ACK_DATA, 64'hCAFE_F00D_5555_AAAA, 1, 4'd0, 1);
        set_row(4, L1_UNCACHED_WRITE, 32'h5000_0010, 3'd1, 64'h0BAD_C0DE_8765_4321, 4,
                D_ACCESS_ACK, 64'd0, 0, 4'd0, 0);
        set_row(5, L1_READ_MISS, 32'h6000_0100, 3'd2, 64'd0, 5, D_GRANT_DATA,
                64'h0123_4567_89AB_CDEF, 1, 4'd9, 1);
        set_row(6, L1_WRITE_BACK, 32'h7000_0140, 3'd2, 64'hFEED_FACE_1357_9BDF, 0,
                D_RELEASE_ACK, 64'd0, 0, 4'd0, 1);
        set_row(7, L1_UNCACHED_READ, 32'h8000_0018, 3'd1, 64'h1020_3040_5060_7080, 2,
                D_ACCESS_ACK_DATA, 64'h2468_ACE0_1122_3344, 0, 4'd0, 0);
        set_row(8, L1_WRITE_MISS, 32'h9000_0180, 3'd1, 64'd0, 1, D_GRANT_DATA,
                64'h5A5A_A5A5_0F0F_F0F0, 0, 4'd15, 0);
        set_row(9, L1_UNCACHED_WRITE, 32'hA000_0020, 3'd2, 64'h7777_8888_9999_0000, 6,
                D_ACCESS_ACK, 64'd0, 0, 4'd0, 1);

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1;
        @(negedge clk);
        check_true(!a_valid && !c_valid && !e_valid && !l1_data_valid,
                   "a valid output is high after reset");
        check_true(l1_req_ready, "l1_req_ready is low after reset");

        // Source IDs rotate from 0, one step per accepted request
        src = 4'd0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i, src);
            src = src + 4'd1;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (16 + NUM_ROWS * (MAX_DELAY + 40)) @(posedge clk);
        $display("Watchdog expired before all rows completed, errors so far: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tidc_l1_adapter.sv
// L1 TileLink adapter top level
// Source pool, request FSM, message builder and D channel matcher
`timescale 1ns/1ps
`default_nettype none

`include "tidc_defs.svh"

module tidc_l1_adapter (
    input  logic                        clk,
    input  logic                        rst_n,
    // L1 request and returned data
    input  logic                        l1_req_valid,
    output logic                        l1_req_ready,
    input  tidc_pkg::l1_req_e           l1_req_type,
    input  logic [`TIDC_ADDR_W-1:0]     l1_req_addr,
    input  tidc_pkg::perm_u             l1_req_perm,
    input  logic [`TIDC_DATA_W-1:0]     l1_req_data,
    output logic                        l1_data_valid,
    output logic [`TIDC_DATA_W-1:0]     l1_data,
    output logic                        l1_data_error,
    // Channel A
    output logic                        a_valid,
    output logic [2:0]                  a_opcode,
    output logic [2:0]                  a_param,
    output logic [3:0]                  a_size,
    output logic [`TIDC_SOURCE_W-1:0]   a_source,
    output logic [`TIDC_ADDR_W-1:0]     a_address,
    output logic [`TIDC_DATA_W-1:0]     a_data,
    output logic [`TIDC_DATA_W/8-1:0]   a_mask,
    input  logic                        a_ready,
    // Channel C
    output logic                        c_valid,
    output logic [2:0]                  c_opcode,
    output logic [2:0]                  c_param,
    output logic [3:0]                  c_size,
    output logic [`TIDC_SOURCE_W-1:0]   c_source,
    output logic [`TIDC_ADDR_W-1:0]     c_address,
    output logic [`TIDC_DATA_W-1:0]     c_data,
    input  logic                        c_ready,
    // Channel D
    input  logic                        d_valid,
    input  logic [2:0]                  d_opcode,
    input  logic [`TIDC_SOURCE_W-1:0]   d_source,
    input  logic [`TIDC_SINK_W-1:0]     d_sink,
    input  logic [`TIDC_DATA_W-1:0]     d_data,
    input  logic                        d_error,
    output logic                        d_ready,
    // Channel E
    output logic                        e_valid,
    output logic [`TIDC_SINK_W-1:0]     e_sink,
    input  logic                        e_ready
);

    import tidc_pkg::*;

    logic                      req_accept;
    logic                      pool_avail;
    logic [`TIDC_SOURCE_W-1:0] grant_id;
    logic [`TIDC_SOURCE_W-1:0] cur_source;
    logic [`TIDC_SINK_W-1:0]   grant_sink;
    logic                      msg_done;
    logic                      resp_done;
    logic                      wait_active;
    msg_kind_e                 msg_kind;
    wait_kind_e                wait_kind;

    tidc_source_pool u_pool (
        .clk      (clk),
        .rst_n    (rst_n),
        .alloc    (req_accept),
        .free     (resp_done),
        .free_id  (cur_source),
        .avail    (pool_avail),
        .grant_id (grant_id)
    );

    tidc_request_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .l1_req_valid (l1_req_valid),
        .l1_req_type  (l1_req_type),
        .pool_avail   (pool_avail),
        .msg_done     (msg_done),
        .resp_done    (resp_done),
        .l1_req_ready (l1_req_ready),
        .req_accept   (req_accept),
        .msg_kind     (msg_kind),
        .wait_kind    (wait_kind),
        .wait_active  (wait_active)
    );

    tidc_message_builder u_build (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_accept  (req_accept),
        .l1_req_addr (l1_req_addr),
        .l1_req_perm (l1_req_perm),
        .l1_req_data (l1_req_data),
        .source_id   (grant_id),
        .msg_kind    (msg_kind),
        .grant_sink  (grant_sink),
        .a_ready     (a_ready),
        .c_ready     (c_ready),
        .e_ready     (e_ready),
        .a_valid     (a_valid),
        .a_opcode    (a_opcode),
        .a_param     (a_param),
        .a_size      (a_size),
        .a_source    (a_source),
        .a_address   (a_address),
        .a_data      (a_data),
        .a_mask      (a_mask),
        .c_valid     (c_valid),
        .c_opcode    (c_opcode),
        .c_param     (c_param),
        .c_size      (c_size),
        .c_source    (c_source),
        .c_address   (c_address),
        .c_data      (c_data),
        .e_valid     (e_valid),
        .e_sink      (e_sink),
        .msg_done    (msg_done),
        .cur_source  (cur_source)
    );

    tidc_response_match u_match (
        .clk           (clk),
        .rst_n         (rst_n),
        .wait_active   (wait_active),
        .wait_kind     (wait_kind),
        .cur_source    (cur_source),
        .d_valid       (d_valid),
        .d_opcode      (d_opcode),
        .d_source      (d_source),
        .d_sink        (d_sink),
        .d_data        (d_data),
        .d_error       (d_error),
        .d_ready       (d_ready),
        .resp_done     (resp_done),
        .grant_sink    (grant_sink),
        .l1_data_valid (l1_data_valid),
        .l1_data       (l1_data),
        .l1_data_error (l1_data_error)
    );

endmodule

`default_nettype wire

//--- tidc_response_match.sv
// Channel D response matcher
// Qualifies beats by opcode and source, returns data to L1
`timescale 1ns/1ps
`default_nettype none

`include "tidc_defs.svh"

module tidc_response_match (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wait_active,
    input  tidc_pkg::wait_kind_e        wait_kind,
    input  logic [`TIDC_SOURCE_W-1:0]   cur_source,
    input  logic                        d_valid,
    input  logic [2:0]                  d_opcode,
    input  logic [`TIDC_SOURCE_W-1:0]   d_source,
    input  logic [`TIDC_SINK_W-1:0]     d_sink,
    input  logic [`TIDC_DATA_W-1:0]     d_data,
    input  logic                        d_error,
    output logic                        d_ready,
    output logic                        resp_done,
    output logic [`TIDC_SINK_W-1:0]     grant_sink,
    output logic                        l1_data_valid,
    output logic [`TIDC_DATA_W-1:0]     l1_data,
    output logic                        l1_data_error
);

    import tidc_pkg::*;

    logic op_hit;
    logic has_data;
    logic beat_hit;

    assign d_ready = 1'b1;

    always_comb begin
        case (wait_kind)
            WAIT_GRANT:       op_hit = (d_opcode == D_GRANT) || (d_opcode == D_GRANT_DATA);
            WAIT_RELEASE_ACK: op_hit = (d_opcode == D_RELEASE_ACK);
            WAIT_ACCESS_ACK:  op_hit = (d_opcode == D_ACCESS_ACK) ||
                                       (d_opcode == D_ACCESS_ACK_DATA);
            default:          op_hit = 1'b0;
        endcase
    end

    assign has_data = (d_opcode == D_GRANT_DATA) || (d_opcode == D_ACCESS_ACK_DATA);

    // Stray beats with a foreign source or opcode are dropped here
    assign beat_hit = d_valid && d_ready && wait_active && op_hit && (d_source == cur_source);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_done     <= 1'b0;
            l1_data_valid <= 1'b0;
            grant_sink    <= '0;
        end else begin
            resp_done     <= beat_hit;
            l1_data_valid <= beat_hit && has_data;
            if (beat_hit && (wait_kind == WAIT_GRANT)) begin
                grant_sink <= d_sink;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_hit && has_data) begin
            l1_data       <= d_data;
            l1_data_error <= d_error;
        end
    end

endmodule

`default_nettype wire

//--- tidc_message_builder.sv
// Request capture and A, C, E channel message formatting
// Fields are combinational from the captured request and msg_kind
`timescale 1ns/1ps
`default_nettype none

`include "tidc_defs.svh"

module tidc_message_builder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_accept,
    input  logic [`TIDC_ADDR_W-1:0]     l1_req_addr,
    input  tidc_pkg::perm_u             l1_req_perm,
    input  logic [`TIDC_DATA_W-1:0]     l1_req_data,
    input  logic [`TIDC_SOURCE_W-1:0]   source_id,
    input  tidc_pkg::msg_kind_e         msg_kind,
    input  logic [`TIDC_SINK_W-1:0]     grant_sink,
    input  logic                        a_ready,
    input  logic                        c_ready,
    input  logic                        e_ready,
    output logic                        a_valid,
    output logic [2:0]                  a_opcode,
    output logic [2:0]                  a_param,
    output logic [3:0]                  a_size,
    output logic [`TIDC_SOURCE_W-1:0]   a_source,
    output logic [`TIDC_ADDR_W-1:0]     a_address,
    output logic [`TIDC_DATA_W-1:0]     a_data,
    output logic [`TIDC_DATA_W/8-1:0]   a_mask,
    output logic                        c_valid,
    output logic [2:0]                  c_opcode,
    output logic [2:0]                  c_param,
    output logic [3:0]                  c_size,
    output logic [`TIDC_SOURCE_W-1:0]   c_source,
    output logic [`TIDC_ADDR_W-1:0]     c_address,
    output logic [`TIDC_DATA_W-1:0]     c_data,
    output logic                        e_valid,
    output logic [`TIDC_SINK_W-1:0]     e_sink,
    output logic                        msg_done,
    output logic [`TIDC_SOURCE_W-1:0]   cur_source
);

    import tidc_pkg::*;

    logic [`TIDC_ADDR_W-1:0]   addr_q;
    perm_u                     perm_q;
    logic [`TIDC_DATA_W-1:0]   data_q;
    logic [`TIDC_SOURCE_W-1:0] source_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            source_q <= '0;
        end else if (req_accept) begin
            source_q <= source_id;
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            addr_q <= l1_req_addr;
            perm_q <= l1_req_perm;
            data_q <= l1_req_data;
        end
    end

    assign cur_source = source_q;

    // ==============================
    // Channel A
    // ==============================
    always_comb begin
        a_valid  = 1'b1;
        a_opcode = A_ACQUIRE_BLOCK;
        a_param  = 3'd0;
        a_data   = '0;
        case (msg_kind)
            MSG_ACQUIRE: begin
                a_param = perm_q.grow;
            end
            MSG_GET: begin
                a_opcode = A_GET;
            end
            MSG_PUT: begin
                a_opcode = A_PUT_FULL_DATA;
                a_data   = data_q;
            end
            default: begin
                a_valid = 1'b0;
            end
        endcase
    end

    assign a_size    = 4'(`TIDC_LINE_LOG2);
    assign a_source  = source_q;
    assign a_address = addr_q;
    assign a_mask    = `TIDC_FULL_MASK;

    // ==============================
    // Channels C and E
    // ==============================
    assign c_valid   = (msg_kind == MSG_RELEASE_DATA);
    assign c_opcode  = C_RELEASE_DATA;
    assign c_param   = perm_q.shrink;
    assign c_size    = 4'(`TIDC_LINE_LOG2);
    assign c_source  = source_q;
    assign c_address = addr_q;
    assign c_data    = data_q;

    assign e_valid = (msg_kind == MSG_GRANT_ACK);
    assign e_sink  = grant_sink;

    // Only one channel is active at a time
    assign msg_done = (a_valid && a_ready) || (c_valid && c_ready) || (e_valid && e_ready);

endmodule

`default_nettype wire

//--- tidc_request_ctrl.sv
// Transaction FSM for the L1 adapter
// Decodes the L1 request type and sequences send, wait and acknowledge
`timescale 1ns/1ps
`default_nettype none

module tidc_request_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   l1_req_valid,
    input  tidc_pkg::l1_req_e      l1_req_type,
    input  logic                   pool_avail,
    input  logic                   msg_done,
    input  logic                   resp_done,
    output logic                   l1_req_ready,
    output logic                   req_accept,
    output tidc_pkg::msg_kind_e    msg_kind,
    output tidc_pkg::wait_kind_e   wait_kind,
    output logic                   wait_active
);

    import tidc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT,
        ST_ACK
    } state_e;

    state_e     state;
    msg_kind_e  first_msg;
    wait_kind_e first_wait;

    // ==============================
    // Request decode
    // ==============================
    always_comb begin
        first_msg  = MSG_NONE;
        first_wait = WAIT_GRANT;
        case (l1_req_type)
            L1_READ_MISS, L1_WRITE_MISS: begin
                first_msg = MSG_ACQUIRE;
            end
            L1_WRITE_BACK: begin
                first_msg  = MSG_RELEASE_DATA;
                first_wait = WAIT_RELEASE_ACK;
            end
            L1_UNCACHED_READ: begin
                first_msg  = MSG_GET;
                first_wait = WAIT_ACCESS_ACK;
            end
            L1_UNCACHED_WRITE: begin
                first_msg  = MSG_PUT;
                first_wait = WAIT_ACCESS_ACK;
            end
            default: begin
                first_msg = MSG_NONE;
            end
        endcase
    end

    assign l1_req_ready = (state == ST_IDLE) && pool_avail;

    // Unknown types complete the handshake but never start a transaction
    assign req_accept = l1_req_ready && l1_req_valid && (first_msg != MSG_NONE);

    // Closed during the resp_done cycle so a repeated beat is not counted twice
    assign wait_active = (state == ST_WAIT) && !resp_done;

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            msg_kind  <= MSG_NONE;
            wait_kind <= WAIT_GRANT;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_accept) begin
                        state     <= ST_SEND;
                        msg_kind  <= first_msg;
                        wait_kind <= first_wait;
                    end
                end
                ST_SEND: begin
                    if (msg_done) begin
                        state    <= ST_WAIT;
                        msg_kind <= MSG_NONE;
                    end
                end
                ST_WAIT: begin
                    if (resp_done) begin
                        // Grants still owe a GrantAck on E
                        if (wait_kind == WAIT_GRANT) begin
                            state    <= ST_ACK;
                            msg_kind <= MSG_GRANT_ACK;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_ACK: begin
                    if (msg_done) begin
                        state    <= ST_IDLE;
                        msg_kind <= MSG_NONE;
                    end
                end
                default: begin
                    state    <= ST_IDLE;
                    msg_kind <= MSG_NONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- tidc_source_pool.sv
// Rotating allocator of TileLink source IDs
// Busy bit per ID, search starts at the rotating pointer
`timescale 1ns/1ps
`default_nettype none

`include "tidc_defs.svh"

module tidc_source_pool (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      alloc,
    input  logic                      free,
    input  logic [`TIDC_SOURCE_W-1:0] free_id,
    output logic                      avail,
    output logic [`TIDC_SOURCE_W-1:0] grant_id
);

    logic [`TIDC_NUM_SOURCES-1:0] busy;
    logic [`TIDC_SOURCE_W-1:0]    ptr;

    assign avail = ~&busy;

    // First free ID at or after the pointer, wrapping around
    always_comb begin
        logic [`TIDC_SOURCE_W-1:0] idx;
        logic                      found;
        found    = 1'b0;
        idx      = ptr;
        grant_id = ptr;
        for (int i = 0; i < `TIDC_NUM_SOURCES; i++) begin
            idx = ptr + `TIDC_SOURCE_W'(i);
            if (!found && !busy[idx]) begin
                grant_id = idx;
                found    = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            ptr  <= '0;
        end else begin
            if (free) begin
                busy[free_id] <= 1'b0;
            end
            // Allocation wins if both hit the same ID
            if (alloc) begin
                busy[grant_id] <= 1'b1;
                ptr            <= grant_id + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tidc_pkg.sv
// Opcode, request, message and permission types for the L1 adapter
// Includes the permission union shared by Acquire and Release
`default_nettype none

package tidc_pkg;

    // ==============================
    // TileLink opcodes
    // ==============================
    typedef enum logic [2:0] {
        A_PUT_FULL_DATA = 3'd0,
        A_GET           = 3'd4,
        A_ACQUIRE_BLOCK = 3'd6
    } a_opcode_e;

    typedef enum logic [2:0] {
        C_RELEASE_DATA = 3'd7
    } c_opcode_e;

    typedef enum logic [2:0] {
        D_ACCESS_ACK      = 3'd0,
        D_ACCESS_ACK_DATA = 3'd1,
        D_GRANT           = 3'd4,
        D_GRANT_DATA      = 3'd5,
        D_RELEASE_ACK     = 3'd6
    } d_opcode_e;

    // ==============================
    // Adapter-side encodings
    // ==============================

    // Request kinds issued by the L1 controller
    typedef enum logic [2:0] {
        L1_READ_MISS      = 3'd0,
        L1_WRITE_MISS     = 3'd1,
        L1_WRITE_BACK     = 3'd2,
        L1_UNCACHED_READ  = 3'd3,
        L1_UNCACHED_WRITE = 3'd4
    } l1_req_e;

    // Message currently presented by the builder
    typedef enum logic [2:0] {
        MSG_NONE,
        MSG_ACQUIRE,
        MSG_RELEASE_DATA,
        MSG_GET,
        MSG_PUT,
        MSG_GRANT_ACK
    } msg_kind_e;

    // Response family awaited on channel D
    typedef enum logic [1:0] {
        WAIT_GRANT,
        WAIT_RELEASE_ACK,
        WAIT_ACCESS_ACK
    } wait_kind_e;

    // Permission transfers, TileLink param encodings
    typedef enum logic [2:0] {
        GROW_NTOB = 3'd0,
        GROW_NTOT = 3'd1,
        GROW_BTOT = 3'd2
    } grow_e;

    typedef enum logic [2:0] {
        SHRINK_TTON = 3'd1,
        SHRINK_BTON = 3'd2
    } shrink_e;

    // Same L1 word, read as grow for Acquire and as shrink for Release
    typedef union packed {
        grow_e   grow;
        shrink_e shrink;
    } perm_u;

endpackage

`default_nettype wire

//--- tidc_defs.svh
// Bus widths and transfer sizes for the L1 TileLink adapter
// Include-guarded, shared by every RTL block
`ifndef TIDC_DEFS_SVH
`define TIDC_DEFS_SVH

// ==============================
// TileLink field widths
// ==============================
`define TIDC_ADDR_W       32
`define TIDC_DATA_W       64
`define TIDC_SOURCE_W     4
`define TIDC_SINK_W       4

// ==============================
// Pool and transfer sizes
// ==============================

// Number of source IDs, one per encoding of TIDC_SOURCE_W
`define TIDC_NUM_SOURCES  16

// log2 of a 32-byte cache line, sent in a_size and c_size
`define TIDC_LINE_LOG2    5

// One enable bit per byte of a data beat
`define TIDC_FULL_MASK    8'hFF

`endif
